/* common/exec_pkg.sv */
package exec_pkg;

   // ************************************************************
   // basic widths.
   // ************************************************************
   typedef logic [31:0] data_t;
   typedef logic [2:0]  oper_t;
   typedef logic [4:0]  func_t;

   // ************************************************************
   // operation classes.
   // ************************************************************
   localparam oper_t OPER_ALUS = 3'd0;  // signed alu op.
   localparam oper_t OPER_ALUU = 3'd1;  // unsigned alu op.
   localparam oper_t OPER_MFHI = 3'd2;  // sent with FUNC_AND.
   localparam oper_t OPER_MFLO = 3'd3;  // sent with FUNC_AND.
   localparam oper_t OPER_MTHI = 3'd4;
   localparam oper_t OPER_MTLO = 3'd5;
   localparam oper_t OPER_MFC0 = 3'd6;

   // ************************************************************
   // function codes.
   // ************************************************************
   // zero is reserved for "no multiply/divide".
   localparam func_t FUNC_NONE = 5'd0;
   localparam func_t FUNC_AND  = 5'd1;
   localparam func_t FUNC_OR   = 5'd2;
   localparam func_t FUNC_XOR  = 5'd3;
   localparam func_t FUNC_NOR  = 5'd4;
   localparam func_t FUNC_LUI  = 5'd5;
   localparam func_t FUNC_SLL  = 5'd6;
   localparam func_t FUNC_SRL  = 5'd7;
   localparam func_t FUNC_SRA  = 5'd8;
   localparam func_t FUNC_ADD  = 5'd9;
   localparam func_t FUNC_SUB  = 5'd10;
   localparam func_t FUNC_SLT  = 5'd11;
   localparam func_t FUNC_MUL  = 5'd12;
   localparam func_t FUNC_DIV  = 5'd13;

   // iteration cycles of the mul/div unit.
   localparam int MULDIV_STEPS = 32;

   // ************************************************************
   // request and result.
   // ************************************************************
   typedef struct packed {
      oper_t oper;
      func_t func;
      data_t source_a;
      data_t source_b;
      data_t cp0_rt_data;  // value of the cp0 register being read.
   } exec_req_t;

   typedef struct packed {
      data_t result;
      logic  write;
      logic  ov;           // overflow exception pulse.
   } exec_res_t;

endpackage

/* rtl/exec_issue.sv */
`timescale 1ns/1ps

module exec_issue (
   input  logic                clk,
   input  logic                reset,
   input  logic                in_valid,
   input  exec_pkg::exec_req_t req,
   input  exec_pkg::func_t     mulalu_func,
   input  logic                mulalu_busy,
   output logic                issue_valid,
   output exec_pkg::exec_req_t issue_req,
   output logic                mulalu_start,
   output logic                busy
);
   import exec_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         issue_req <= req;
      end
   end

   // mul/div sitting in the issue register kicks off the unit.
   assign mulalu_start = issue_valid & (mulalu_func != FUNC_NONE);

   // covers the cycle before the unit reports busy itself.
   assign busy = mulalu_start | mulalu_busy;

   // ************************************************************
   // checks.
   // ************************************************************
   a_no_issue_when_busy : assert property (
      @(posedge clk) disable iff (reset) in_valid |-> !busy
   ) else $error("exec_issue: in_valid while busy");

   // unit must take over the busy level on the next cycle.
   a_start_then_busy : assert property (
      @(posedge clk) disable iff (reset) mulalu_start |=> mulalu_busy
   ) else $error("exec_issue: mulalu did not go busy after start");

endmodule

/* rtl/sglalu.sv */
`timescale 1ns/1ps

module sglalu (
   input  exec_pkg::oper_t oper,
   input  exec_pkg::func_t func,
   input  exec_pkg::data_t cp0_rt_data,
   input  exec_pkg::data_t source_a,
   input  exec_pkg::data_t source_b,
   input  exec_pkg::data_t hi,
   input  exec_pkg::data_t lo,
   output exec_pkg::data_t result,
   output logic            mulalu_sign,
   output exec_pkg::func_t mulalu_func,
   output logic            hi_write,
   output logic            lo_write,
   output exec_pkg::data_t hi_write_data,
   output exec_pkg::data_t lo_write_data,
   output logic            ov
);
   import exec_pkg::*;

   data_t      add_result;
   data_t      sub_result;
   logic       slt_bit;
   logic [4:0] shamt;
   logic       add_ov;
   logic       sub_ov;

   assign add_result = source_a + source_b;
   assign sub_result = source_a - source_b;
   assign shamt      = source_b[4:0];  // low five bits only.

   // signed compare only under ALUS.
   assign slt_bit = (oper == OPER_ALUS) ? ($signed(source_a) < $signed(source_b)) :
                                          (source_a < source_b);

   // ************************************************************
   // multiply/divide request.
   // ************************************************************
   assign mulalu_func = (func == FUNC_MUL || func == FUNC_DIV) ? func : FUNC_NONE;
   assign mulalu_sign = (mulalu_func != FUNC_NONE) && (oper != OPER_ALUU);

   // ************************************************************
   // hi/lo moves.
   // ************************************************************
   assign hi_write      = (oper == OPER_MTHI);
   assign hi_write_data = source_a;
   assign lo_write      = (oper == OPER_MTLO);
   assign lo_write_data = source_a;

   always_comb begin
      result = '0;
      if (oper == OPER_MFC0) begin
         result = cp0_rt_data;
      end else begin
         case (func)
            FUNC_AND : begin
               if (oper == OPER_MFHI) begin
                  result = hi;
               end else if (oper == OPER_MFLO) begin
                  result = lo;
               end else begin
                  result = source_a & source_b;
               end
            end
            FUNC_OR  : result = source_a | source_b;
            FUNC_XOR : result = source_a ^ source_b;
            FUNC_NOR : result = ~(source_a | source_b);
            FUNC_LUI : result = {source_b[15:0], 16'h0000};
            FUNC_SLL : result = source_a << shamt;
            FUNC_SRL : result = source_a >> shamt;
            FUNC_SRA : result = data_t'($signed(source_a) >>> shamt);
            FUNC_ADD : result = add_result;
            FUNC_SUB : result = sub_result;
            FUNC_SLT : result = {31'b0, slt_bit};
            default  : result = '0;  // mul/div results go to hi/lo.
         endcase
      end
   end

   // operands share a sign that the result lost.
   assign add_ov = (source_a[31] == source_b[31]) && (add_result[31] != source_a[31]);
   // operand signs differ, result sign follows b.
   assign sub_ov = (source_a[31] != source_b[31]) && (sub_result[31] != source_a[31]);

   assign ov = (oper == OPER_ALUS) &&
               (((func == FUNC_ADD) && add_ov) || ((func == FUNC_SUB) && sub_ov));

endmodule

/* mulalu/mulalu.sv */
`timescale 1ns/1ps

module mulalu (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,
   input  exec_pkg::func_t func,
   input  logic            sign,
   input  exec_pkg::data_t source_a,
   input  exec_pkg::data_t source_b,
   output logic            busy,
   output logic            done,
   output exec_pkg::data_t hi_result,
   output exec_pkg::data_t lo_result
);
   import exec_pkg::*;

   localparam int CNT_W = $clog2(MULDIV_STEPS);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_FIX
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] step;
   logic [63:0]      acc;       // {hi, lo} working register.
   data_t            mag_b;     // multiplicand or divisor.
   logic             op_div;
   logic             neg_res;   // product or quotient negative.
   logic             neg_rem;   // remainder follows dividend.
   data_t            abs_a;
   data_t            abs_b;
   logic [32:0]      mul_sum;
   logic [32:0]      div_diff;
   logic [63:0]      acc_next;
   logic [63:0]      product;
   data_t            rem_mag;
   data_t            quo_mag;

   assign abs_a = (sign && source_a[31]) ? -source_a : source_a;
   assign abs_b = (sign && source_b[31]) ? -source_b : source_b;

   // ************************************************************
   // one iteration step.
   // ************************************************************
   assign mul_sum  = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, mag_b} : 33'd0);
   assign div_diff = acc[63:31] - {1'b0, mag_b};  // shifted remainder minus divisor.

   always_comb begin
      if (!op_div) begin
         acc_next = {mul_sum, acc[31:1]};
      end else if (div_diff[32]) begin
         acc_next = {acc[62:0], 1'b0};  // restore.
      end else begin
         acc_next = {div_diff[31:0], acc[30:0], 1'b1};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= ST_IDLE;
         step  <= '0;
      end else begin
         case (state)
            ST_IDLE : begin
               if (start) begin
                  state <= ST_RUN;
                  step  <= '0;
               end
            end
            ST_RUN : begin
               step <= step + 1'b1;
               if (step == CNT_W'(MULDIV_STEPS - 1)) begin
                  state <= ST_FIX;
               end
            end
            default : state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && start) begin
         acc     <= {32'd0, abs_a};
         mag_b   <= abs_b;
         op_div  <= (func == FUNC_DIV);
         neg_res <= sign & (source_a[31] ^ source_b[31]);
         neg_rem <= sign & source_a[31];
      end else if (state == ST_RUN) begin
         acc <= acc_next;
      end
   end

   // ************************************************************
   // sign fix, presented during the done cycle.
   // ************************************************************
   assign product = neg_res ? -acc : acc;
   assign rem_mag = acc[63:32];
   assign quo_mag = acc[31:0];

   assign hi_result = op_div ? (neg_rem ? -rem_mag : rem_mag) : product[63:32];
   assign lo_result = op_div ? (neg_res ? -quo_mag : quo_mag) : product[31:0];

   assign busy = (state != ST_IDLE);
   assign done = (state == ST_FIX);

   a_start_when_idle : assert property (
      @(posedge clk) disable iff (reset) start |-> !busy
   ) else $error("mulalu: start while busy");

   // fixed latency, steps plus the fix cycle.
   a_done_latency : assert property (
      @(posedge clk) disable iff (reset) start |-> ##(MULDIV_STEPS + 1) done
   ) else $error("mulalu: done not on time");

endmodule

/* rtl/hilo_regs.sv */
`timescale 1ns/1ps

module hilo_regs (
   input  logic            clk,
   input  logic            reset,
   input  logic            hi_write,
   input  logic            lo_write,
   input  logic            muldiv_done,
   input  exec_pkg::data_t hi_write_data,
   input  exec_pkg::data_t lo_write_data,
   input  exec_pkg::data_t hi_result,
   input  exec_pkg::data_t lo_result,
   output exec_pkg::data_t hi,
   output exec_pkg::data_t lo
);
   import exec_pkg::*;

   always_ff @(posedge clk) begin
      if (reset) begin
         hi <= '0;
         lo <= '0;
      end else if (muldiv_done) begin
         hi <= hi_result;  // remainder or upper product.
         lo <= lo_result;
      end else begin
         if (hi_write) begin
            hi <= hi_write_data;
         end
         if (lo_write) begin
            lo <= lo_write_data;
         end
      end
   end

   // busy hold-off keeps moves away from mul/div completion.
   a_single_source : assert property (
      @(posedge clk) disable iff (reset) muldiv_done |-> !(hi_write || lo_write)
   ) else $error("hilo_regs: move-to collides with mul/div done");

endmodule

/* rtl/exec_writeback.sv */
`timescale 1ns/1ps

module exec_writeback (
   input  logic                clk,
   input  logic                reset,
   input  logic                issue_valid,
   input  logic                is_muldiv,
   input  exec_pkg::data_t     alu_result,
   input  logic                ov,
   input  exec_pkg::oper_t     oper,
   output logic                out_valid,
   output exec_pkg::exec_res_t res
);
   import exec_pkg::*;

   data_t result_q;
   logic  write_q;
   logic  ov_q;
   logic  writes_reg;

   // ops that return a value to the register file.
   assign writes_reg = (oper == OPER_ALUS) || (oper == OPER_ALUU) ||
                       (oper == OPER_MFHI) || (oper == OPER_MFLO) ||
                       (oper == OPER_MFC0);

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         write_q   <= 1'b0;
         ov_q      <= 1'b0;
      end else begin
         out_valid <= issue_valid;
         write_q   <= issue_valid & writes_reg & ~is_muldiv & ~ov;
         ov_q      <= issue_valid & ov;  // exception instead of write.
      end
   end

   always_ff @(posedge clk) begin
      if (issue_valid) begin
         result_q <= alu_result;
      end
   end

   assign res.result = result_q;
   assign res.write  = write_q;
   assign res.ov     = ov_q;

endmodule

/* rtl/exec_top.sv */
`timescale 1ns/1ps

module exec_top (
   input  logic                clk,
   input  logic                reset,
   input  logic                in_valid,
   input  exec_pkg::exec_req_t req,
   output logic                busy,
   output logic                out_valid,
   output exec_pkg::exec_res_t res
);
   import exec_pkg::*;

   logic      issue_valid;
   exec_req_t issue_req;
   logic      mulalu_start;
   logic      mulalu_busy;
   logic      mulalu_done;
   logic      mulalu_sign;
   func_t     mulalu_func;
   data_t     alu_result;
   logic      alu_ov;
   logic      alu_hi_write;
   logic      alu_lo_write;
   logic      hi_wr_en;
   logic      lo_wr_en;
   data_t     hi_write_data;
   data_t     lo_write_data;
   data_t     hi_result;
   data_t     lo_result;
   data_t     hi;
   data_t     lo;
   logic      is_muldiv;

   // ************************************************************
   // issue stage.
   // ************************************************************
   exec_issue i_exec_issue (
      .clk          (clk),
      .reset        (reset),
      .in_valid     (in_valid),
      .req          (req),
      .mulalu_func  (mulalu_func),
      .mulalu_busy  (mulalu_busy),
      .issue_valid  (issue_valid),
      .issue_req    (issue_req),
      .mulalu_start (mulalu_start),
      .busy         (busy)
   );

   sglalu i_sglalu (
      .oper          (issue_req.oper),
      .func          (issue_req.func),
      .cp0_rt_data   (issue_req.cp0_rt_data),
      .source_a      (issue_req.source_a),
      .source_b      (issue_req.source_b),
      .hi            (hi),
      .lo            (lo),
      .result        (alu_result),
      .mulalu_sign   (mulalu_sign),
      .mulalu_func   (mulalu_func),
      .hi_write      (alu_hi_write),
      .lo_write      (alu_lo_write),
      .hi_write_data (hi_write_data),
      .lo_write_data (lo_write_data),
      .ov            (alu_ov)
   );

   mulalu i_mulalu (
      .clk       (clk),
      .reset     (reset),
      .start     (mulalu_start),
      .func      (mulalu_func),
      .sign      (mulalu_sign),
      .source_a  (issue_req.source_a),
      .source_b  (issue_req.source_b),
      .busy      (mulalu_busy),
      .done      (mulalu_done),
      .hi_result (hi_result),
      .lo_result (lo_result)
   );

   // moves only count when the issue slot is live.
   assign hi_wr_en  = issue_valid & alu_hi_write;
   assign lo_wr_en  = issue_valid & alu_lo_write;
   assign is_muldiv = (mulalu_func != FUNC_NONE);

   hilo_regs i_hilo_regs (
      .clk           (clk),
      .reset         (reset),
      .hi_write      (hi_wr_en),
      .lo_write      (lo_wr_en),
      .muldiv_done   (mulalu_done),
      .hi_write_data (hi_write_data),
      .lo_write_data (lo_write_data),
      .hi_result     (hi_result),
      .lo_result     (lo_result),
      .hi            (hi),
      .lo            (lo)
   );

   // ************************************************************
   // writeback stage.
   // ************************************************************
   exec_writeback i_exec_writeback (
      .clk         (clk),
      .reset       (reset),
      .issue_valid (issue_valid),
      .is_muldiv   (is_muldiv),
      .alu_result  (alu_result),
      .ov          (alu_ov),
      .oper        (issue_req.oper),
      .out_valid   (out_valid),
      .res         (res)
   );

endmodule

/* testbench/exec_checker.sv */
`timescale 1ns/1ps

module exec_checker (
   input  logic                clk,
   input  logic                reset,
   input  logic                in_valid,
   input  exec_pkg::exec_req_t req,
   input  logic                busy,
   input  logic                out_valid,
   input  exec_pkg::exec_res_t res,
   output int                  error_count,
   output int                  check_count,
   output int                  pending
);
   import exec_pkg::*;

   typedef struct packed {
      data_t       result;
      logic        write;
      logic        ov;
      logic [31:0] due;     // cycle at which out_valid is seen.
   } expect_t;

   expect_t exp_q[$];
   expect_t head;
   expect_t item;
   data_t   hi_m;
   data_t   lo_m;
   int      cycle;
   int      busy_left;
   logic    after_reset;

   // ************************************************************
   // reference model.
   // ************************************************************
   function automatic expect_t model_op(exec_req_t r, data_t hi_v, data_t lo_v);
      expect_t     e;
      logic [32:0] wide;
      logic [63:0] ext;
      data_t       a;
      data_t       b;
      a       = r.source_a;
      b       = r.source_b;
      e       = '0;
      e.write = 1'b1;
      case (r.oper)
         OPER_MFHI : e.result = hi_v;
         OPER_MFLO : e.result = lo_v;
         OPER_MFC0 : e.result = r.cp0_rt_data;
         OPER_MTHI, OPER_MTLO : e.write = 1'b0;
         default : begin
            case (r.func)
               FUNC_AND : e.result = a & b;
               FUNC_OR  : e.result = a | b;
               FUNC_XOR : e.result = a ^ b;
               FUNC_NOR : e.result = ~(a | b);
               FUNC_LUI : e.result = {b[15:0], 16'h0000};
               FUNC_SLL : e.result = a << b[4:0];
               FUNC_SRL : e.result = a >> b[4:0];
               FUNC_SRA : begin
                  ext      = {{32{a[31]}}, a} >> b[4:0];  // sign fill from the top.
                  e.result = ext[31:0];
               end
               FUNC_ADD : begin
                  wide     = {a[31], a} + {b[31], b};
                  e.result = wide[31:0];
                  e.ov     = (r.oper == OPER_ALUS) && (wide[32] != wide[31]);
               end
               FUNC_SUB : begin
                  wide     = {a[31], a} - {b[31], b};
                  e.result = wide[31:0];
                  e.ov     = (r.oper == OPER_ALUS) && (wide[32] != wide[31]);
               end
               FUNC_SLT : begin
                  // borrow out of a 33-bit difference.
                  if (r.oper == OPER_ALUS) begin
                     wide = {a[31], a} - {b[31], b};
                  end else begin
                     wide = {1'b0, a} - {1'b0, b};
                  end
                  e.result = data_t'(wide[32]);
               end
               default : e.write = 1'b0;  // mul/div lands in hi/lo.
            endcase
         end
      endcase
      if (e.ov) begin
         e.write = 1'b0;
      end
      return e;
   endfunction

   task automatic update_hilo(input exec_req_t r);
      logic signed [63:0] pa;
      logic signed [63:0] pb;
      logic signed [63:0] full;
      if (r.oper == OPER_ALUU) begin
         pa = {32'd0, r.source_a};
         pb = {32'd0, r.source_b};
      end else begin
         pa = {{32{r.source_a[31]}}, r.source_a};
         pb = {{32{r.source_b[31]}}, r.source_b};
      end
      if (r.func == FUNC_MUL) begin
         full = pa * pb;
         hi_m = full[63:32];
         lo_m = full[31:0];
      end else begin
         full = pa / pb;  // truncates toward zero.
         lo_m = full[31:0];
         full = pa % pb;
         hi_m = full[31:0];
      end
   endtask

   // ************************************************************
   // compare on every rising edge.
   // ************************************************************
   always @(posedge clk) begin
      if (reset) begin
         exp_q.delete();
         hi_m        = '0;
         lo_m        = '0;
         cycle       = 0;
         busy_left   = 0;
         error_count = 0;
         check_count = 0;
         pending     = 0;
         after_reset = 1'b1;
      end else begin
         cycle++;
         if (after_reset) begin
            if (out_valid || busy || res.write || res.ov) begin
               $display("%0t: outputs not idle right after reset", $time);
               error_count++;
            end
            after_reset = 1'b0;
         end
         if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            head = exp_q.pop_front();
            if (!out_valid) begin
               $display("%0t: out_valid missing for an issued operation", $time);
               error_count++;
            end else begin
               check_count++;
               if (res.write !== head.write || res.ov !== head.ov) begin
                  $display("FAILED %0t: write/ov %b/%b, expected %b/%b", $time,
                           res.write, res.ov, head.write, head.ov);
                  error_count++;
               end else if (head.write && res.result !== head.result) begin
                  $display("FAILED %0t: result %h, expected %h", $time,
                           res.result, head.result);
                  error_count++;
               end
            end
         end else if (out_valid) begin
            $display("%0t: out_valid with no operation in flight", $time);
            error_count++;
         end
         // start cycle, the steps and the fix cycle.
         if (busy !== (busy_left != 0)) begin
            $display("FAILED %0t: busy %b, expected %b", $time, busy, busy_left != 0);
            error_count++;
         end
         if (busy_left != 0) begin
            busy_left--;
         end
         if (in_valid) begin
            item     = model_op(req, hi_m, lo_m);
            item.due = cycle + 2;
            exp_q.push_back(item);
            if (req.oper == OPER_MTHI) begin
               hi_m = req.source_a;
            end else if (req.oper == OPER_MTLO) begin
               lo_m = req.source_a;
            end else if ((req.func == FUNC_MUL || req.func == FUNC_DIV) &&
                         (req.oper == OPER_ALUS || req.oper == OPER_ALUU)) begin
               update_hilo(req);
               busy_left = MULDIV_STEPS + 2;
            end
         end
         pending = exp_q.size();
      end
   end

endmodule

/* testbench/tb_exec_top.sv */
`timescale 1ns/1ps

module tb_exec_top;
   import exec_pkg::*;

   localparam int NUM_OPS        = 400;
   localparam int TIMEOUT_CYCLES = NUM_OPS * 40;

   logic      clk;
   logic      reset;
   logic      in_valid;
   exec_req_t req;
   logic      busy;
   logic      out_valid;
   exec_res_t res;
   int        error_count;
   int        check_count;
   int        pending;
   int        op_count;
   int        cycle_count = 0;
   int        pick;
   logic      hi_side;
   data_t     opa;
   data_t     opb;

   always #5 clk = ~clk;

   exec_top i_exec_top (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (in_valid),
      .req       (req),
      .busy      (busy),
      .out_valid (out_valid),
      .res       (res)
   );

   exec_checker i_exec_checker (
      .clk         (clk),
      .reset       (reset),
      .in_valid    (in_valid),
      .req         (req),
      .busy        (busy),
      .out_valid   (out_valid),
      .res         (res),
      .error_count (error_count),
      .check_count (check_count),
      .pending     (pending)
   );

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // edge values now and then, to hit overflow.
   function automatic data_t pick_operand();
      case ($urandom_range(0, 11))
         0       : return 32'h7fff_ffff;
         1       : return 32'h8000_0000;
         2       : return 32'hffff_ffff;
         3       : return 32'h0000_0001;
         default : return $urandom;
      endcase
   endfunction

   // called on a falling edge; holds off while busy.
   task automatic issue_op(input oper_t oper, input func_t func, input data_t a,
                           input data_t b);
      while (busy) @(negedge clk);
      in_valid        = 1'b1;
      req.oper        = oper;
      req.func        = func;
      req.source_a    = a;
      req.source_b    = b;
      req.cp0_rt_data = $urandom;
      op_count++;
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   initial begin
      void'($urandom(32'h1d3c4ca4));
      clk      = 1'b0;
      reset    = 1'b1;
      in_valid = 1'b0;
      req      = '0;
      op_count = 0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);  // one idle cycle for the post-reset look.
      while (op_count < NUM_OPS) begin
         pick = $urandom_range(0, 99);
         opa  = pick_operand();
         opb  = pick_operand();
         if (pick < 55) begin
            issue_op($urandom_range(0, 1) ? OPER_ALUU : OPER_ALUS,
                     func_t'($urandom_range(FUNC_AND, FUNC_SLT)), opa, opb);
         end else if (pick < 65) begin
            hi_side = 1'($urandom_range(0, 1));
            issue_op(hi_side ? OPER_MTHI : OPER_MTLO, FUNC_AND, opa, opb);
            if ($urandom_range(0, 1) == 1) begin
               issue_op(hi_side ? OPER_MFHI : OPER_MFLO, FUNC_AND, opa, opb);
            end
         end else if (pick < 72) begin
            issue_op($urandom_range(0, 1) ? OPER_MFHI : OPER_MFLO, FUNC_AND, opa, opb);
         end else if (pick < 77) begin
            issue_op(OPER_MFC0, FUNC_AND, opa, opb);
         end else begin
            if (opb == '0) begin
               opb = 32'd7;  // never divide by zero.
            end
            issue_op($urandom_range(0, 1) ? OPER_ALUU : OPER_ALUS,
                     $urandom_range(0, 1) ? FUNC_MUL : FUNC_DIV, opa, opb);
            issue_op(OPER_MFHI, FUNC_AND, opa, opb);
            issue_op(OPER_MFLO, FUNC_AND, opa, opb);
         end
         if ($urandom_range(0, 3) == 0) begin
            @(negedge clk);
         end
      end
      while (busy) @(negedge clk);
      repeat (4) @(negedge clk);
      $display("checks: %0d, errors: %0d, outstanding: %0d",
               check_count, error_count, pending);
      if (error_count == 0 && pending == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* exec_top.f */
common/exec_pkg.sv
rtl/exec_issue.sv
rtl/sglalu.sv
mulalu/mulalu.sv
rtl/hilo_regs.sv
rtl/exec_writeback.sv
rtl/exec_top.sv
testbench/exec_checker.sv
testbench/tb_exec_top.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_exec_top
FILELIST   = exec_top.f
BUILD_DIR  = obj_dir
LOG        = sim.log
VFLAGS     = --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG) || ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
